/* Makefile */
VERILATOR ?= verilator
TOP       ?= tdd_tb
FILELIST  ?= tdd_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) design/tdd_consts.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/tdd_combiner.sv */
`timescale 1ns/10ps
`default_nettype none

module tdd_combiner (
  input  logic clk,
  input  logic resetn,
  input  logic tx_act,
  input  logic rx_act,
  output logic tx_en,
  output logic rx_en
);

  // Transmit wins any overlap
  // The receiver is never enabled while the antenna is being driven
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_en <= 1'b0;
      rx_en <= 1'b0;
    end else begin
      tx_en <= tx_act;
      rx_en <= rx_act && !tx_act;
    end
  end

endmodule

`default_nettype wire

/* design/tdd_consts.svh */
`ifndef TDD_CONSTS_SVH
`define TDD_CONSTS_SVH

// Width of the frame counter and of every position compared against it
`define TDD_CNT_W 16

// Width of the burst count and of the burst down-counter
`define TDD_BURST_W 16

// Register map of the host write port
`define TDD_ADDR_FRAME 3'd0
`define TDD_ADDR_DELAY 3'd1
`define TDD_ADDR_BURST 3'd2
`define TDD_ADDR_TXWIN 3'd3
`define TDD_ADDR_RXWIN 3'd4

`endif

/* design/tdd_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tdd_consts.svh"

module tdd_counter (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    tdd_enable,
  input  logic                    tdd_sync,
  input  logic                    tdd_sync_rst,
  input  logic [`TDD_CNT_W-1:0]   frame_length,
  input  logic [`TDD_CNT_W-1:0]   startup_delay,
  input  logic [`TDD_BURST_W-1:0] burst_count,
  output logic [`TDD_CNT_W-1:0]   counter,
  output tdd_pkg::tdd_state_t     state,
  output logic                    endof_frame
);

  import tdd_pkg::*;

  // Shadow copies of the configuration
  logic [`TDD_CNT_W-1:0]   frame_length_q;
  logic [`TDD_CNT_W-1:0]   startup_delay_q;
  logic [`TDD_BURST_W-1:0] burst_count_q;

  // Burst bookkeeping and the control flags derived from it
  logic [`TDD_BURST_W-1:0] burst_counter;
  logic                    delay_done;
  logic                    last_burst;
  logic                    endof_burst;
  tdd_state_t              state_ns;

  // Configuration only follows the register block while enabled
  // A disabled controller keeps the last values it saw
  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_length_q  <= '0;
      startup_delay_q <= '0;
      burst_count_q   <= '0;
    end else if (tdd_enable) begin
      frame_length_q  <= frame_length;
      startup_delay_q <= startup_delay;
      burst_count_q   <= burst_count;
    end
  end

  // ****************************************
  // Frame and burst state machine
  // ****************************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= IDLE;
    end else begin
      state <= state_ns;
    end
  end

  always_comb begin
    state_ns = state;
    case (state)
      IDLE: begin
        if (tdd_enable) begin
          state_ns = ARMED;
        end
      end
      ARMED: begin
        // Without a startup delay the first frame begins right after sync
        if (!tdd_enable) begin
          state_ns = IDLE;
        end else if (tdd_sync) begin
          state_ns = (startup_delay_q == '0) ? RUNNING : WAITING;
        end
      end
      WAITING: begin
        if (delay_done) begin
          state_ns = RUNNING;
        end
      end
      RUNNING: begin
        // A finished burst rearms only if the host still wants frames
        // Continuous mode stops at the first frame end seen with enable low
        if (endof_burst) begin
          state_ns = tdd_enable ? ARMED : IDLE;
        end else if (endof_frame && (burst_counter == '0) && !tdd_enable) begin
          state_ns = IDLE;
        end
      end
      default: state_ns = IDLE;
    endcase
  end

  // ****************************************
  // Flags and counters
  // ****************************************

  // High in the cycle where the delay counter sits on startup_delay
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_done <= 1'b0;
    end else begin
      delay_done <= (state == WAITING) && (counter == (startup_delay_q - 1'b1));
    end
  end

  // Frame end is the last counter value of a running frame
  assign endof_frame = (state == RUNNING) && (counter == frame_length_q);
  assign endof_burst = endof_frame && last_burst;

  // The burst counter reloads while armed and counts frames down while running
  // last_burst marks the frame in which the counter holds one
  always_ff @(posedge clk) begin
    if (!resetn) begin
      burst_counter <= '0;
      last_burst    <= 1'b0;
    end else if (state == ARMED) begin
      burst_counter <= burst_count_q;
      last_burst    <= (burst_count_q == `TDD_BURST_W'd1);
    end else if (endof_frame && (burst_counter != '0)) begin
      burst_counter <= burst_counter - 1'b1;
      last_burst    <= (burst_counter == `TDD_BURST_W'd2);
    end
  end

  // The counter doubles as delay timer in WAITING and frame position in RUNNING
  always_ff @(posedge clk) begin
    if (!resetn) begin
      counter <= '0;
    end else if (tdd_sync && tdd_sync_rst) begin
      counter <= '0;
    end else if (state == WAITING) begin
      counter <= delay_done ? '0 : counter + 1'b1;
    end else if (state == RUNNING) begin
      counter <= endof_frame ? '0 : counter + 1'b1;
    end else begin
      counter <= '0;
    end
  end

endmodule

`default_nettype wire

/* design/tdd_pkg.sv */
`default_nettype none

`include "tdd_consts.svh"

package tdd_pkg;

  // Controller states in the order the frame counter walks through them
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ARMED   = 2'd1,
    WAITING = 2'd2,
    RUNNING = 2'd3
  } tdd_state_t;

  // One switching window with an inclusive start and an exclusive end
  typedef struct packed {
    logic [`TDD_CNT_W-1:0] on;
    logic [`TDD_CNT_W-1:0] off;
  } tdd_win_t;

  // A write word is either a plain scalar or a pair of window positions
  // The register address decides which view applies
  typedef union packed {
    logic [31:0] value;
    tdd_win_t    win;
  } tdd_wdata_u;

  // Host write request as held stable during the handshake
  typedef struct packed {
    logic [2:0] addr;
    tdd_wdata_u data;
  } tdd_wr_t;

endpackage

`default_nettype wire

/* design/tdd_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tdd_consts.svh"

module tdd_regs (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    wr_req,
  input  tdd_pkg::tdd_wr_t        wr,
  output logic                    wr_ack,
  output logic [`TDD_CNT_W-1:0]   frame_length,
  output logic [`TDD_CNT_W-1:0]   startup_delay,
  output logic [`TDD_BURST_W-1:0] burst_count,
  output tdd_pkg::tdd_win_t       tx_win,
  output tdd_pkg::tdd_win_t       rx_win
);

  // A write is taken on the first edge that sees req high while ack is low
  logic wr_accept;

  assign wr_accept = wr_req && !wr_ack;

  // ****************************************
  // Four-phase handshake
  // ****************************************

  // Ack rises together with the store and drops once the host releases req
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ack <= 1'b0;
    end else if (wr_accept) begin
      wr_ack <= 1'b1;
    end else if (!wr_req) begin
      wr_ack <= 1'b0;
    end
  end

  // ****************************************
  // Configuration registers
  // ****************************************

  // Scalar registers take the low bits of the value view
  // Window registers take the on/off view of the same word
  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_length  <= '0;
      startup_delay <= '0;
      burst_count   <= '0;
      tx_win        <= '0;
      rx_win        <= '0;
    end else if (wr_accept) begin
      case (wr.addr)
        `TDD_ADDR_FRAME: frame_length  <= wr.data.value[`TDD_CNT_W-1:0];
        `TDD_ADDR_DELAY: startup_delay <= wr.data.value[`TDD_CNT_W-1:0];
        `TDD_ADDR_BURST: burst_count   <= wr.data.value[`TDD_BURST_W-1:0];
        `TDD_ADDR_TXWIN: tx_win        <= wr.data.win;
        `TDD_ADDR_RXWIN: rx_win        <= wr.data.win;
        // Unknown addresses still complete the handshake but change nothing
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/tdd_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tdd_consts.svh"

module tdd_top (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  wr_req,
  input  tdd_pkg::tdd_wr_t      wr,
  output logic                  wr_ack,
  input  logic                  tdd_enable,
  input  logic                  tdd_sync,
  input  logic                  tdd_sync_rst,
  output tdd_pkg::tdd_state_t   tdd_state,
  output logic [`TDD_CNT_W-1:0] tdd_counter,
  output logic                  tdd_endof_frame,
  output logic                  tx_en,
  output logic                  rx_en
);

  import tdd_pkg::*;

  // Configuration from the register block
  logic [`TDD_CNT_W-1:0]   frame_length;
  logic [`TDD_CNT_W-1:0]   startup_delay;
  logic [`TDD_BURST_W-1:0] burst_count;
  tdd_win_t                tx_win;
  tdd_win_t                rx_win;

  // Raw window results before arbitration
  logic                    tx_act;
  logic                    rx_act;

  tdd_regs regs_i (
    .clk           (clk),
    .resetn        (resetn),
    .wr_req        (wr_req),
    .wr            (wr),
    .wr_ack        (wr_ack),
    .frame_length  (frame_length),
    .startup_delay (startup_delay),
    .burst_count   (burst_count),
    .tx_win        (tx_win),
    .rx_win        (rx_win)
  );

  tdd_counter counter_i (
    .clk           (clk),
    .resetn        (resetn),
    .tdd_enable    (tdd_enable),
    .tdd_sync      (tdd_sync),
    .tdd_sync_rst  (tdd_sync_rst),
    .frame_length  (frame_length),
    .startup_delay (startup_delay),
    .burst_count   (burst_count),
    .counter       (tdd_counter),
    .state         (tdd_state),
    .endof_frame   (tdd_endof_frame)
  );

  // Both paths decode the same counter against their own window
  tdd_window tx_window_i (
    .clk     (clk),
    .resetn  (resetn),
    .counter (tdd_counter),
    .state   (tdd_state),
    .win     (tx_win),
    .act     (tx_act)
  );

  tdd_window rx_window_i (
    .clk     (clk),
    .resetn  (resetn),
    .counter (tdd_counter),
    .state   (tdd_state),
    .win     (rx_win),
    .act     (rx_act)
  );

  tdd_combiner combiner_i (
    .clk    (clk),
    .resetn (resetn),
    .tx_act (tx_act),
    .rx_act (rx_act),
    .tx_en  (tx_en),
    .rx_en  (rx_en)
  );

endmodule

`default_nettype wire

/* design/tdd_window.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tdd_consts.svh"

module tdd_window (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`TDD_CNT_W-1:0] counter,
  input  tdd_pkg::tdd_state_t   state,
  input  tdd_pkg::tdd_win_t     win,
  output logic                  act
);

  import tdd_pkg::*;

  // Counter position falls inside the window
  logic in_window;

  // Start is inclusive and end is exclusive
  // An empty or inverted window therefore never matches
  assign in_window = (counter >= win.on) && (counter < win.off);

  // ****************************************
  // Registered window output
  // ****************************************

  // Only running frames open a window, so the delay phase stays quiet
  always_ff @(posedge clk) begin
    if (!resetn) begin
      act <= 1'b0;
    end else begin
      act <= (state == RUNNING) && in_window;
    end
  end

endmodule

`default_nettype wire

/* sim/tdd_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module tdd_asserts (
  input logic clk,
  input logic resetn,
  input logic wr_req,
  input logic wr_ack,
  input logic tx_en,
  input logic rx_en
);

  // Ack may only rise in answer to a pending request
  ack_rise_needs_req: assert property (
    @(posedge clk) disable iff (!resetn) $rose(wr_ack) |-> $past(wr_req)
  ) else $error("wr_ack rose without wr_req");

  // Ack may only drop once the host has released its request
  ack_fall_after_req: assert property (
    @(posedge clk) disable iff (!resetn) $fell(wr_ack) |-> !$past(wr_req)
  ) else $error("wr_ack fell while wr_req was still high");

  // The antenna is never driven and listened to at once
  enables_exclusive: assert property (
    @(posedge clk) disable iff (!resetn) !(tx_en && rx_en)
  ) else $error("tx_en and rx_en high together");

endmodule

bind tdd_top tdd_asserts asserts_i (
  .clk    (clk),
  .resetn (resetn),
  .wr_req (wr_req),
  .wr_ack (wr_ack),
  .tx_en  (tx_en),
  .rx_en  (rx_en)
);

`default_nettype wire

/* sim/tdd_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tdd_clkgen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic resetn
);

  // Free-running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset is released on a rising edge after the hold time
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tdd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tdd_consts.svh"

module tdd_tb;

  import tdd_pkg::*;

  // Frame length used by every test, so a frame is FRAME_LEN+1 cycles
  localparam int FRAME_LEN = 19;
  localparam int FRAME_CYC = FRAME_LEN + 1;
  // Frames over all tests (5 + 1 + 2 + 2 + 3) plus delay, writes and slack
  localparam int TIMEOUT_CYC = FRAME_CYC * 13 + 800;

  logic clk;
  logic resetn;
  logic wr_req;
  tdd_wr_t wr;
  logic wr_ack;
  logic tdd_enable;
  logic tdd_sync;
  logic tdd_sync_rst;
  tdd_state_t tdd_state;
  logic [`TDD_CNT_W-1:0] tdd_counter;
  logic tdd_endof_frame;
  logic tx_en;
  logic rx_en;

  // Bookkeeping for errors, tests and the run length
  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int cycles = 0;
  logic [31:0] lfsr = 32'he93159f9;

  // Window model as programmed by the host, plus counter/state history
  tdd_win_t tx_win_m = '0;
  tdd_win_t rx_win_m = '0;
  logic [`TDD_CNT_W-1:0] ctr_d1;
  logic [`TDD_CNT_W-1:0] ctr_d2;
  tdd_state_t st_d1;
  tdd_state_t st_d2;

  tdd_clkgen clkgen_i (.clk(clk), .resetn(resetn));

  tdd_top dut_i (
    .clk             (clk),
    .resetn          (resetn),
    .wr_req          (wr_req),
    .wr              (wr),
    .wr_ack          (wr_ack),
    .tdd_enable      (tdd_enable),
    .tdd_sync        (tdd_sync),
    .tdd_sync_rst    (tdd_sync_rst),
    .tdd_state       (tdd_state),
    .tdd_counter     (tdd_counter),
    .tdd_endof_frame (tdd_endof_frame),
    .tx_en           (tx_en),
    .rx_en           (rx_en)
  );

  // ****************************************
  // Helpers
  // ****************************************

  // Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Expected {tx_en, rx_en} for a counter/state pair two cycles back
  function automatic logic [1:0] expected_en(input logic [`TDD_CNT_W-1:0] ctr,
                                             input tdd_state_t st,
                                             input tdd_win_t txw,
                                             input tdd_win_t rxw);
    logic tx_hit;
    logic rx_hit;
    tx_hit = (st == RUNNING) && (ctr >= txw.on) && (ctr < txw.off);
    rx_hit = (st == RUNNING) && (ctr >= rxw.on) && (ctr < rxw.off);
    return {tx_hit, rx_hit && !tx_hit};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, errors - err_start);
    end
  endtask

  // Four-phase write, preceded by a random idle gap
  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    int n;
    repeat (rand_bits(2)) @(posedge clk);
    @(negedge clk);
    check_val("wr_ack", wr_ack, 0);
    @(posedge clk);
    wr_req <= 1'b1;
    wr.addr <= addr;
    wr.data.value <= data;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wr_ack && n < 8);
    if (!wr_ack) begin
      $display("Write to address %0d was never acknowledged", addr);
      errors++;
    end
    @(posedge clk);
    wr_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (wr_ack && n < 8);
    if (wr_ack) begin
      $display("Ack for address %0d stayed high after the request dropped", addr);
      errors++;
    end
    if (addr == `TDD_ADDR_TXWIN) tx_win_m = data;
    if (addr == `TDD_ADDR_RXWIN) rx_win_m = data;
  endtask

  task automatic wait_state(input tdd_state_t s, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (tdd_state != s && n < limit);
    if (tdd_state != s) begin
      $display("State %s not reached within %0d cycles", s.name(), limit);
      errors++;
    end
  endtask

  task automatic pulse_sync();
    @(posedge clk);
    tdd_sync <= 1'b1;
    @(posedge clk);
    tdd_sync <= 1'b0;
  endtask

  task automatic write_windows(input tdd_win_t txw, input tdd_win_t rxw);
    write_reg(`TDD_ADDR_TXWIN, txw);
    write_reg(`TDD_ADDR_RXWIN, rxw);
  endtask

  // ****************************************
  // Compare process and run limit
  // ****************************************

  always @(negedge clk) begin
    logic [1:0] exp;
    if (!resetn) begin
      ctr_d1 = '0;
      ctr_d2 = '0;
      st_d1 = IDLE;
      st_d2 = IDLE;
    end else begin
      exp = expected_en(ctr_d2, st_d2, tx_win_m, rx_win_m);
      check_val("tx_en", tx_en, exp[1]);
      check_val("rx_en", rx_en, exp[0]);
      ctr_d2 = ctr_d1;
      st_d2 = st_d1;
      ctr_d1 = tdd_counter;
      st_d1 = tdd_state;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int e0;
    int n;
    int d;
    int eofs;
    int last_eof;
    tdd_win_t txw;
    tdd_win_t rxw;
    wr_req = 1'b0;
    wr = '0;
    tdd_enable = 1'b0;
    tdd_sync = 1'b0;
    tdd_sync_rst = 1'b0;
    @(posedge resetn);

    // Handshake on every register, one unknown address included
    e0 = errors;
    write_reg(`TDD_ADDR_FRAME, FRAME_LEN);
    write_reg(`TDD_ADDR_DELAY, 0);
    write_reg(`TDD_ADDR_BURST, 3);
    txw.on = 2;
    txw.off = 6;
    rxw.on = 9;
    rxw.off = 15;
    write_windows(txw, rxw);
    write_reg(3'd7, 32'hdeadbeef);
    end_test("write handshake", e0);

    // Burst of three frames without delay
    e0 = errors;
    @(posedge clk);
    tdd_enable <= 1'b1;
    wait_state(ARMED, 5);
    pulse_sync();
    eofs = 0;
    last_eof = 0;
    n = 0;
    while (n < 3 * FRAME_CYC + 2 * FRAME_CYC) begin
      @(negedge clk);
      n++;
      // Three back-to-back frames count 0 to FRAME_LEN, then the counter rests at 0
      check_val("tdd_counter", tdd_counter,
                (n <= 3 * FRAME_CYC) ? (n - 1) % FRAME_CYC : 0);
      if (tdd_endof_frame) begin
        if (eofs > 0) check_val("frame spacing", n - last_eof, FRAME_CYC);
        eofs++;
        last_eof = n;
      end
    end
    check_val("endof_frame count", eofs, 3);
    check_val("tdd_state", tdd_state, ARMED);
    end_test("burst of three", e0);

    // Startup delay before the first running cycle
    e0 = errors;
    d = 1 + rand_bits(3);
    write_reg(`TDD_ADDR_DELAY, d);
    write_reg(`TDD_ADDR_BURST, 1);
    pulse_sync();
    n = 0;
    do begin
      @(negedge clk);
      n++;
      // The delay timer counts up from 0 while waiting
      if (tdd_state == WAITING) check_val("tdd_counter", tdd_counter, n - 1);
    end while (tdd_state != RUNNING && n < d + 10);
    check_val("cycles to RUNNING", n, d + 2);
    wait_state(ARMED, 2 * FRAME_CYC);
    write_reg(`TDD_ADDR_DELAY, 0);
    end_test("startup delay", e0);

    // Random windows that never overlap
    e0 = errors;
    txw.on = rand_bits(2);
    txw.off = txw.on + 2 + rand_bits(3);
    rxw.on = txw.off + rand_bits(2);
    rxw.off = rxw.on + 1 + rand_bits(2);
    write_windows(txw, rxw);
    write_reg(`TDD_ADDR_BURST, 2);
    pulse_sync();
    wait_state(RUNNING, 5);
    wait_state(ARMED, 3 * FRAME_CYC);
    end_test("separate windows", e0);

    // Overlap where transmit must win
    e0 = errors;
    txw.on = 2 + rand_bits(2);
    txw.off = txw.on + 6;
    rxw.on = txw.on + 3;
    rxw.off = rxw.on + 8;
    write_windows(txw, rxw);
    pulse_sync();
    wait_state(RUNNING, 5);
    wait_state(ARMED, 3 * FRAME_CYC);
    end_test("overlapping windows", e0);

    // Continuous frames stopped by enable at the next frame end
    e0 = errors;
    write_reg(`TDD_ADDR_BURST, 0);
    pulse_sync();
    wait_state(RUNNING, 5);
    repeat (FRAME_CYC + FRAME_CYC / 2) @(negedge clk);
    @(posedge clk);
    tdd_enable <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!tdd_endof_frame && n < FRAME_CYC + 2);
    if (!tdd_endof_frame) begin
      $display("No frame end seen after enable dropped");
      errors++;
    end
    @(negedge clk);
    check_val("tdd_state", tdd_state, IDLE);
    repeat (3) @(negedge clk);
    check_val("tx_en", tx_en, 0);
    check_val("rx_en", rx_en, 0);
    end_test("continuous stop", e0);

    $display("Tests: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tdd_top.f */
+incdir+design
design/tdd_pkg.sv
design/tdd_regs.sv
design/tdd_counter.sv
design/tdd_window.sv
design/tdd_combiner.sv
design/tdd_top.sv
sim/tdd_clkgen.sv
sim/tdd_asserts.sv
sim/tdd_tb.sv
